// ==== hw/ompss_pkg.sv ====
package ompss_pkg;

    // Accelerator count and id width
    localparam int MAX_ACCS = 4;
    localparam int ACC_BITS = $clog2(MAX_ACCS);

    // Per-accelerator command subqueue
    localparam int SUBQUEUE_LEN = 4;
    localparam int SUBQUEUE_BITS = $clog2(SUBQUEUE_LEN);

    localparam int CMD_WIDTH = 64;

    typedef logic [ACC_BITS-1:0] acc_id_t;

    // One bit per accelerator
    typedef logic [MAX_ACCS-1:0] acc_mask_t;

    // Command, completion and lock words
    typedef logic [CMD_WIDTH-1:0] cmd_word_t;

    typedef logic [SUBQUEUE_BITS-1:0] subq_ptr_t;

    typedef enum logic {
        LOCK_FREE,
        LOCK_HELD
    } lock_state_e;

endpackage

// ==== hw/cmd_in_dispatch.sv ====
`timescale 1ns/100ps

module cmd_in_dispatch (
    input  logic                 aclk,
    input  logic                 arst_n,
    // Commands from the host
    input  logic                 cmdin_in_valid,
    output logic                 cmdin_in_ready,
    input  ompss_pkg::acc_id_t   cmdin_in_tid,
    input  ompss_pkg::cmd_word_t cmdin_in_data,
    // Commands to the accelerators
    output logic                 cmdin_out_valid,
    input  logic                 cmdin_out_ready,
    output ompss_pkg::acc_id_t   cmdin_out_tdest,
    output ompss_pkg::cmd_word_t cmdin_out_data,
    // Completion notice from the collector
    input  logic                 acc_free,
    input  ompss_pkg::acc_id_t   acc_free_id
);

    ompss_pkg::cmd_word_t subq_mem [ompss_pkg::MAX_ACCS][ompss_pkg::SUBQUEUE_LEN];
    ompss_pkg::subq_ptr_t wr_ptr [ompss_pkg::MAX_ACCS];
    ompss_pkg::subq_ptr_t rd_ptr [ompss_pkg::MAX_ACCS];
    logic [ompss_pkg::SUBQUEUE_BITS:0] count [ompss_pkg::MAX_ACCS];

    ompss_pkg::acc_mask_t idle;
    ompss_pkg::acc_mask_t nempty;
    ompss_pkg::acc_mask_t eligible;
    ompss_pkg::acc_mask_t push_sel;
    ompss_pkg::acc_mask_t pop_sel;

    ompss_pkg::acc_id_t rr_ptr;
    ompss_pkg::acc_id_t pick_id;
    logic pick_valid;

    logic push;
    logic load;
    logic out_xfer;

    // Top count bit set means the subqueue is full
    assign cmdin_in_ready = !count[cmdin_in_tid][ompss_pkg::SUBQUEUE_BITS];
    assign push = cmdin_in_valid && cmdin_in_ready;

    assign out_xfer = cmdin_out_valid && cmdin_out_ready;
    assign load = pick_valid && (!cmdin_out_valid || cmdin_out_ready);

    always_comb begin
        for (int i = 0; i < ompss_pkg::MAX_ACCS; i++) begin
            nempty[i] = (count[i] != '0);
        end
    end

    // The accelerator sitting in the output register is no longer a candidate
    always_comb begin
        eligible = idle & nempty;
        if (cmdin_out_valid) begin
            eligible[cmdin_out_tdest] = 1'b0;
        end
    end

    // Round-robin pick starting at rr_ptr, lowest offset wins
    always_comb begin
        ompss_pkg::acc_id_t idx;
        pick_valid = 1'b0;
        pick_id = rr_ptr;
        for (int i = ompss_pkg::MAX_ACCS - 1; i >= 0; i--) begin
            idx = rr_ptr + ompss_pkg::acc_id_t'(i);
            if (eligible[idx]) begin
                pick_valid = 1'b1;
                pick_id = idx;
            end
        end
    end

    always_comb begin
        push_sel = '0;
        pop_sel = '0;
        if (push) begin
            push_sel[cmdin_in_tid] = 1'b1;
        end
        if (load) begin
            pop_sel[pick_id] = 1'b1;
        end
    end

    // Subqueue pointers and fill counts
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < ompss_pkg::MAX_ACCS; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < ompss_pkg::MAX_ACCS; i++) begin
                if (push_sel[i]) begin
                    wr_ptr[i] <= wr_ptr[i] + 1'b1;
                end
                if (pop_sel[i]) begin
                    rd_ptr[i] <= rd_ptr[i] + 1'b1;
                end
                if (push_sel[i] && !pop_sel[i]) begin
                    count[i] <= count[i] + 1'b1;
                end else if (!push_sel[i] && pop_sel[i]) begin
                    count[i] <= count[i] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            subq_mem[cmdin_in_tid][wr_ptr[cmdin_in_tid]] <= cmdin_in_data;
        end
    end

    // Idle flags, output valid and arbiter pointer
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            idle <= '1;
            cmdin_out_valid <= 1'b0;
            rr_ptr <= '0;
        end else begin
            if (out_xfer) begin
                idle[cmdin_out_tdest] <= 1'b0;
            end
            if (acc_free) begin
                idle[acc_free_id] <= 1'b1;
            end
            if (load) begin
                cmdin_out_valid <= 1'b1;
                rr_ptr <= pick_id + 1'b1;
            end else if (out_xfer) begin
                cmdin_out_valid <= 1'b0;
            end
        end
    end

    // Held stable under back-pressure since load needs ready or an empty slot
    always_ff @(posedge aclk) begin
        if (load) begin
            cmdin_out_data <= subq_mem[pick_id][rd_ptr[pick_id]];
            cmdin_out_tdest <= pick_id;
        end
    end

endmodule

// ==== hw/cmd_out_collect.sv ====
`timescale 1ns/100ps

module cmd_out_collect (
    input  logic                 aclk,
    input  logic                 arst_n,
    // Completions from the accelerators
    input  logic                 cmdout_in_valid,
    output logic                 cmdout_in_ready,
    input  ompss_pkg::acc_id_t   cmdout_in_tid,
    input  ompss_pkg::cmd_word_t cmdout_in_data,
    // Finish notices to the host
    output logic                 finish_out_valid,
    input  logic                 finish_out_ready,
    output ompss_pkg::acc_id_t   finish_out_tdest,
    output ompss_pkg::cmd_word_t finish_out_data,
    // Free pulse to the dispatcher
    output logic                 acc_free,
    output ompss_pkg::acc_id_t   acc_free_id
);

    logic accept;
    logic finish_xfer;

    assign finish_xfer = finish_out_valid && finish_out_ready;

    // Room when empty or draining this cycle
    assign cmdout_in_ready = !finish_out_valid || finish_out_ready;
    assign accept = cmdout_in_valid && cmdout_in_ready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            finish_out_valid <= 1'b0;
            acc_free <= 1'b0;
        end else begin
            if (accept) begin
                finish_out_valid <= 1'b1;
            end else if (finish_xfer) begin
                finish_out_valid <= 1'b0;
            end
            acc_free <= accept;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            finish_out_tdest <= cmdout_in_tid;
            finish_out_data <= cmdout_in_data;
        end
    end

    // The buffer was loaded on the same edge as the pulse, so its tdest is the id
    assign acc_free_id = finish_out_tdest;

endmodule

// ==== hw/lock_manager.sv ====
`timescale 1ns/100ps

module lock_manager (
    input  logic                 aclk,
    input  logic                 arst_n,
    // Lock requests
    input  logic                 lock_in_valid,
    output logic                 lock_in_ready,
    input  ompss_pkg::acc_id_t   lock_in_tid,
    input  ompss_pkg::cmd_word_t lock_in_data,
    // Acknowledgments
    output logic                 lock_out_valid,
    input  logic                 lock_out_ready,
    output ompss_pkg::acc_id_t   lock_out_tdest,
    output ompss_pkg::cmd_word_t lock_out_data
);

    ompss_pkg::lock_state_e state;
    ompss_pkg::lock_state_e next_state;
    ompss_pkg::acc_id_t holder;
    ompss_pkg::acc_id_t next_holder;

    logic acquire;
    logic grant;
    logic accept;

    // One request in flight
    assign lock_in_ready = !lock_out_valid;
    assign accept = lock_in_valid && lock_in_ready;
    assign acquire = lock_in_data[0];

    always_comb begin
        next_state = state;
        next_holder = holder;
        grant = 1'b0;
        case (state)
            ompss_pkg::LOCK_FREE: begin
                // Release of a free lock is answered with 0
                if (acquire) begin
                    next_state = ompss_pkg::LOCK_HELD;
                    next_holder = lock_in_tid;
                    grant = 1'b1;
                end
            end
            ompss_pkg::LOCK_HELD: begin
                if (!acquire && lock_in_tid == holder) begin
                    next_state = ompss_pkg::LOCK_FREE;
                    grant = 1'b1;
                end
            end
            default: begin
                next_state = ompss_pkg::LOCK_FREE;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ompss_pkg::LOCK_FREE;
            holder <= '0;
            lock_out_valid <= 1'b0;
        end else begin
            if (accept) begin
                state <= next_state;
                holder <= next_holder;
                lock_out_valid <= 1'b1;
            end else if (lock_out_ready) begin
                lock_out_valid <= 1'b0;
            end
        end
    end

    // Ack goes back to the requester
    always_ff @(posedge aclk) begin
        if (accept) begin
            lock_out_tdest <= lock_in_tid;
            lock_out_data <= ompss_pkg::cmd_word_t'(grant);
        end
    end

endmodule

// ==== hw/ompss_manager.sv ====
`timescale 1ns/100ps

module ompss_manager (
    input  logic                 aclk,
    input  logic                 arst_n,
    // Host commands
    input  logic                 cmdin_in_valid,
    output logic                 cmdin_in_ready,
    input  ompss_pkg::acc_id_t   cmdin_in_tid,
    input  ompss_pkg::cmd_word_t cmdin_in_data,
    // Commands to accelerators
    output logic                 cmdin_out_valid,
    input  logic                 cmdin_out_ready,
    output ompss_pkg::acc_id_t   cmdin_out_tdest,
    output ompss_pkg::cmd_word_t cmdin_out_data,
    // Accelerator completions
    input  logic                 cmdout_in_valid,
    output logic                 cmdout_in_ready,
    input  ompss_pkg::acc_id_t   cmdout_in_tid,
    input  ompss_pkg::cmd_word_t cmdout_in_data,
    // Finish notices to host
    output logic                 finish_out_valid,
    input  logic                 finish_out_ready,
    output ompss_pkg::acc_id_t   finish_out_tdest,
    output ompss_pkg::cmd_word_t finish_out_data,
    // Lock requests
    input  logic                 lock_in_valid,
    output logic                 lock_in_ready,
    input  ompss_pkg::acc_id_t   lock_in_tid,
    input  ompss_pkg::cmd_word_t lock_in_data,
    // Lock acks
    output logic                 lock_out_valid,
    input  logic                 lock_out_ready,
    output ompss_pkg::acc_id_t   lock_out_tdest,
    output ompss_pkg::cmd_word_t lock_out_data
);

    logic acc_free;
    ompss_pkg::acc_id_t acc_free_id;

    cmd_in_dispatch cmd_in_i (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .cmdin_in_valid  (cmdin_in_valid),
        .cmdin_in_ready  (cmdin_in_ready),
        .cmdin_in_tid    (cmdin_in_tid),
        .cmdin_in_data   (cmdin_in_data),
        .cmdin_out_valid (cmdin_out_valid),
        .cmdin_out_ready (cmdin_out_ready),
        .cmdin_out_tdest (cmdin_out_tdest),
        .cmdin_out_data  (cmdin_out_data),
        .acc_free        (acc_free),
        .acc_free_id     (acc_free_id)
    );

    // Completions free their accelerator in the dispatcher
    cmd_out_collect cmd_out_i (
        .aclk             (aclk),
        .arst_n           (arst_n),
        .cmdout_in_valid  (cmdout_in_valid),
        .cmdout_in_ready  (cmdout_in_ready),
        .cmdout_in_tid    (cmdout_in_tid),
        .cmdout_in_data   (cmdout_in_data),
        .finish_out_valid (finish_out_valid),
        .finish_out_ready (finish_out_ready),
        .finish_out_tdest (finish_out_tdest),
        .finish_out_data  (finish_out_data),
        .acc_free         (acc_free),
        .acc_free_id      (acc_free_id)
    );

    lock_manager lock_i (
        .aclk           (aclk),
        .arst_n         (arst_n),
        .lock_in_valid  (lock_in_valid),
        .lock_in_ready  (lock_in_ready),
        .lock_in_tid    (lock_in_tid),
        .lock_in_data   (lock_in_data),
        .lock_out_valid (lock_out_valid),
        .lock_out_ready (lock_out_ready),
        .lock_out_tdest (lock_out_tdest),
        .lock_out_data  (lock_out_data)
    );

endmodule

// ==== tests/ompss_manager_properties.sv ====
`timescale 1ns/100ps

module ompss_manager_properties (
    input logic                 aclk,
    input logic                 arst_n,
    input logic                 cmdin_out_valid,
    input logic                 cmdin_out_ready,
    input ompss_pkg::acc_id_t   cmdin_out_tdest,
    input ompss_pkg::cmd_word_t cmdin_out_data,
    input logic                 finish_out_valid,
    input logic                 finish_out_ready,
    input ompss_pkg::acc_id_t   finish_out_tdest,
    input ompss_pkg::cmd_word_t finish_out_data,
    input logic                 lock_in_valid,
    input logic                 lock_in_ready,
    input logic                 lock_out_valid,
    input logic                 lock_out_ready,
    input ompss_pkg::acc_id_t   lock_out_tdest,
    input ompss_pkg::cmd_word_t lock_out_data
);

    // Count of failed assertions
    int failures = 0;

    // Output streams hold their word under back-pressure
    cmd_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        cmdin_out_valid && !cmdin_out_ready |=> cmdin_out_valid
            && $stable(cmdin_out_data) && $stable(cmdin_out_tdest))
        else begin
            $error("dispatch output changed while stalled");
            failures++;
        end

    finish_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        finish_out_valid && !finish_out_ready |=> finish_out_valid
            && $stable(finish_out_data) && $stable(finish_out_tdest))
        else begin
            $error("finish output changed while stalled");
            failures++;
        end

    lock_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        lock_out_valid && !lock_out_ready |=> lock_out_valid
            && $stable(lock_out_data) && $stable(lock_out_tdest))
        else begin
            $error("lock ack changed while stalled");
            failures++;
        end

    lock_latency: assert property (@(posedge aclk) disable iff (!arst_n)
        lock_in_valid && lock_in_ready |=> lock_out_valid)
        else begin
            $error("lock ack did not follow its request");
            failures++;
        end

    reset_quiet: assert property (@(posedge aclk)
        !arst_n |-> !cmdin_out_valid && !finish_out_valid && !lock_out_valid)
        else begin
            $error("output valid high during reset");
            failures++;
        end

endmodule

bind ompss_manager ompss_manager_properties props_i (.*);

// ==== tests/ompss_manager_tb.sv ====
`timescale 1ns/100ps

module ompss_manager_tb;

    localparam int MAX_RECORDS = 64;
    localparam int CYCLES_PER_RECORD = 200;

    logic aclk = 1'b0;
    logic arst_n;
    logic cmdin_in_valid, cmdin_in_ready, cmdin_out_valid, cmdin_out_ready;
    logic cmdout_in_valid, cmdout_in_ready, finish_out_valid, finish_out_ready;
    logic lock_in_valid, lock_in_ready, lock_out_valid, lock_out_ready;
    ompss_pkg::acc_id_t cmdin_in_tid, cmdin_out_tdest, cmdout_in_tid;
    ompss_pkg::acc_id_t finish_out_tdest, lock_in_tid, lock_out_tdest;
    ompss_pkg::cmd_word_t cmdin_in_data, cmdin_out_data, cmdout_in_data;
    ompss_pkg::cmd_word_t finish_out_data, lock_in_data, lock_out_data;

    ompss_pkg::cmd_word_t records [4*MAX_RECORDS];
    int num_records;
    int cycle = 0;
    int cycle_limit = 1000000;
    int mismatches = 0;
    int other_errors = 0;
    int stall_cycles = 0;
    integer seed;

    // Expected dispatches in host order, searched per tdest
    ompss_pkg::acc_id_t exp_cmd_id[$];
    ompss_pkg::cmd_word_t exp_cmd_data[$];
    ompss_pkg::acc_id_t fin_id[$];
    ompss_pkg::cmd_word_t fin_data[$];
    ompss_pkg::acc_id_t lk_id[$];
    ompss_pkg::cmd_word_t lk_data[$];
    // Completions waiting to be sent by the accelerator model
    ompss_pkg::acc_id_t cp_id[$];
    ompss_pkg::cmd_word_t cp_data[$];
    int cp_due[$];
    logic cp_model[$];
    logic comp_active = 1'b0;
    logic comp_from_model = 1'b0;
    ompss_pkg::acc_mask_t busy = '0;
    // Accepted commands per accelerator not yet dispatched
    int held [ompss_pkg::MAX_ACCS] = '{default: 0};

    ompss_manager DUT (.*);

    initial begin
        forever #5 aclk = ~aclk;
    end

    task automatic check_dispatch(input string name, input ompss_pkg::acc_id_t exp_id,
            input ompss_pkg::acc_id_t act_id, input ompss_pkg::cmd_word_t exp_data,
            input ompss_pkg::cmd_word_t act_data);
        if (exp_id !== act_id || exp_data !== act_data) begin
            mismatches++;
            $display("mismatch %s: expected id %0d data %h, actual id %0d data %h",
                name, exp_id, exp_data, act_id, act_data);
        end
    endtask

    task automatic check_finish(input string name, input ompss_pkg::acc_id_t exp_id,
            input ompss_pkg::acc_id_t act_id, input ompss_pkg::cmd_word_t exp_data,
            input ompss_pkg::cmd_word_t act_data);
        if (exp_id !== act_id || exp_data !== act_data) begin
            mismatches++;
            $display("mismatch %s: expected tdest %0d data %h, actual tdest %0d data %h",
                name, exp_id, exp_data, act_id, act_data);
        end
    endtask

    task automatic check_lock_ack(input string name, input ompss_pkg::acc_id_t exp_id,
            input ompss_pkg::acc_id_t act_id, input ompss_pkg::cmd_word_t exp_data,
            input ompss_pkg::cmd_word_t act_data);
        if (exp_id !== act_id || exp_data !== act_data) begin
            mismatches++;
            $display("mismatch %s: expected tdest %0d ack %h, actual tdest %0d ack %h",
                name, exp_id, exp_data, act_id, act_data);
        end
    endtask

    task automatic clear_host_inputs();
        cmdin_in_valid = 1'b0;
        lock_in_valid = 1'b0;
    endtask

    // Returns one ns before the edge that accepts the word
    task automatic send_command(input ompss_pkg::acc_id_t id, input ompss_pkg::cmd_word_t data);
        @(negedge aclk);
        clear_host_inputs();
        cmdin_in_valid = 1'b1;
        cmdin_in_tid = id;
        cmdin_in_data = data;
        #4;
        while (!cmdin_in_ready) begin
            stall_cycles++;
            @(negedge aclk);
            #4;
        end
        exp_cmd_id.push_back(id);
        exp_cmd_data.push_back(data);
    endtask

    task automatic send_lock(input ompss_pkg::acc_id_t id, input ompss_pkg::cmd_word_t data,
            input ompss_pkg::cmd_word_t expected);
        @(negedge aclk);
        clear_host_inputs();
        lock_in_valid = 1'b1;
        lock_in_tid = id;
        lock_in_data = data;
        #4;
        while (!lock_in_ready) begin
            @(negedge aclk);
            #4;
        end
        lk_id.push_back(id);
        lk_data.push_back(expected);
    endtask

    task automatic add_completion(input ompss_pkg::acc_id_t id, input ompss_pkg::cmd_word_t data);
        @(negedge aclk);
        clear_host_inputs();
        #2;
        cp_id.push_back(id);
        cp_data.push_back(data);
        cp_due.push_back(cycle);
        cp_model.push_back(1'b0);
    endtask

    // Ready toggling and accelerator model on the falling edge, monitors just before rising
    always begin : monitor
        int pick;
        int delay;
        int queued;
        logic exp_ready;
        @(negedge aclk);
        cmdin_out_ready = ($unsigned($random(seed)) % 4) != 0;
        finish_out_ready = ($unsigned($random(seed)) % 4) != 0;
        lock_out_ready = ($unsigned($random(seed)) % 2) != 0;
        if (!comp_active) begin
            cmdout_in_valid = 1'b0;
            pick = -1;
            for (int i = 0; i < cp_id.size(); i++) begin
                if (pick < 0 && cp_due[i] <= cycle) pick = i;
            end
            if (pick >= 0) begin
                cmdout_in_valid = 1'b1;
                cmdout_in_tid = cp_id[pick];
                cmdout_in_data = cp_data[pick];
                comp_from_model = cp_model[pick];
                comp_active = 1'b1;
                cp_id.delete(pick);
                cp_data.delete(pick);
                cp_due.delete(pick);
                cp_model.delete(pick);
            end
        end
        #4;
        cycle++;
        // The word in the output register has already left its subqueue
        if (cmdin_in_valid) begin
            queued = held[cmdin_in_tid];
            if (cmdin_out_valid && cmdin_out_tdest == cmdin_in_tid) queued--;
            exp_ready = queued < ompss_pkg::SUBQUEUE_LEN;
            if (cmdin_in_ready !== exp_ready) begin
                mismatches++;
                $display("mismatch subqueue ready: expected %0b, actual %0b",
                    exp_ready, cmdin_in_ready);
            end
            if (cmdin_in_ready) held[cmdin_in_tid]++;
        end
        if (cmdin_out_valid && cmdin_out_ready) begin
            held[cmdin_out_tdest]--;
            pick = -1;
            for (int i = 0; i < exp_cmd_id.size(); i++) begin
                if (pick < 0 && exp_cmd_id[i] == cmdin_out_tdest) pick = i;
            end
            if (pick < 0) begin
                other_errors++;
                $display("Unexpected command %h sent to accelerator %0d",
                    cmdin_out_data, cmdin_out_tdest);
            end else begin
                check_dispatch("dispatch", exp_cmd_id[pick], cmdin_out_tdest,
                    exp_cmd_data[pick], cmdin_out_data);
                exp_cmd_id.delete(pick);
                exp_cmd_data.delete(pick);
            end
            if (busy[cmdin_out_tdest]) begin
                other_errors++;
                $display("Accelerator %0d got a command before finishing the last one",
                    cmdin_out_tdest);
            end
            busy[cmdin_out_tdest] = 1'b1;
            delay = 4 + int'($unsigned($random(seed)) % 12);
            cp_id.push_back(cmdin_out_tdest);
            cp_data.push_back(cmdin_out_data + 64'd1);
            cp_due.push_back(cycle + delay);
            cp_model.push_back(1'b1);
        end
        if (cmdout_in_valid && cmdout_in_ready) begin
            fin_id.push_back(cmdout_in_tid);
            fin_data.push_back(cmdout_in_data);
            if (comp_from_model) busy[cmdout_in_tid] = 1'b0;
            comp_active = 1'b0;
        end
        if (finish_out_valid && finish_out_ready) begin
            if (fin_id.size() == 0) begin
                other_errors++;
                $display("Finish notice without any accepted completion");
            end else begin
                check_finish("finish", fin_id[0], finish_out_tdest, fin_data[0], finish_out_data);
                void'(fin_id.pop_front());
                void'(fin_data.pop_front());
            end
        end
        if (lock_out_valid && lock_out_ready) begin
            if (lk_id.size() == 0) begin
                other_errors++;
                $display("Lock acknowledgment without a request");
            end else begin
                check_lock_ack("lock ack", lk_id[0], lock_out_tdest, lk_data[0], lock_out_data);
                void'(lk_id.pop_front());
                void'(lk_data.pop_front());
            end
        end
    end

    initial begin : timeout_watch
        wait (cycle >= cycle_limit);
        other_errors++;
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
            mismatches, other_errors, DUT.props_i.failures);
        $display("Test failed");
        $finish;
    end

    initial begin : stimulus
        ompss_pkg::cmd_word_t kind;
        ompss_pkg::acc_id_t id;
        seed = 32'hcf9a6c3d;
        arst_n = 1'b0;
        cmdin_in_valid = 1'b0;
        cmdin_in_tid = '0;
        cmdin_in_data = '0;
        cmdin_out_ready = 1'b0;
        cmdout_in_valid = 1'b0;
        cmdout_in_tid = '0;
        cmdout_in_data = '0;
        finish_out_ready = 1'b0;
        lock_in_valid = 1'b0;
        lock_in_tid = '0;
        lock_in_data = '0;
        lock_out_ready = 1'b0;
        // Entries the file does not overwrite keep an address marker
        for (int i = 0; i < 4*MAX_RECORDS; i++) begin
            records[i] = ~ompss_pkg::cmd_word_t'(i);
        end
        $readmemh("tests/ompss_input.txt", records);
        num_records = 0;
        while (num_records < MAX_RECORDS
                && records[4*num_records] != ~ompss_pkg::cmd_word_t'(4*num_records)) begin
            num_records++;
        end
        cycle_limit = CYCLES_PER_RECORD * (num_records + 1);
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        arst_n = 1'b1;
        #4;
        if (cmdin_out_valid || finish_out_valid || lock_out_valid) begin
            other_errors++;
            $display("An output valid is high right after reset");
        end
        if (num_records == 0) begin
            other_errors++;
            $display("No stimulus records were read");
        end
        for (int r = 0; r < num_records; r++) begin
            kind = records[4*r];
            id = ompss_pkg::acc_id_t'(records[4*r+1]);
            case (kind)
                64'd0: send_command(id, records[4*r+2]);
                64'd1: add_completion(id, records[4*r+2]);
                64'd2: send_lock(id, records[4*r+2], records[4*r+3]);
                default: begin
                    other_errors++;
                    $display("Record %0d has an unknown kind", r);
                end
            endcase
        end
        @(negedge aclk);
        clear_host_inputs();
        while (exp_cmd_id.size() != 0 || cp_id.size() != 0 || comp_active
                || fin_id.size() != 0 || lk_id.size() != 0) begin
            @(negedge aclk);
        end
        repeat (3) @(negedge aclk);
        if (stall_cycles == 0) begin
            other_errors++;
            $display("A full subqueue never held back a command");
        end
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
            mismatches, other_errors, DUT.props_i.failures);
        if (mismatches + other_errors + DUT.props_i.failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tests/ompss_input.txt ====
// kind id data expected, all hex, one record per line
// kind 0 host command, 1 accelerator completion, 2 lock request (data 1 acquire, 0 release)
1 3 00000000000000a0 0
0 0 0000000000000100 0
0 1 0000000000000200 0
0 3 0000000000000400 0
2 1 0000000000000001 1
2 2 0000000000000001 0
2 2 0000000000000000 0
2 1 0000000000000000 1
2 3 0000000000000000 0
2 3 0000000000000001 1
2 3 0000000000000000 1
0 2 0000000000000300 0
0 2 0000000000000301 0
0 2 0000000000000302 0
0 2 0000000000000303 0
0 2 0000000000000304 0
0 2 0000000000000305 0
0 1 0000000000000201 0
0 0 0000000000000101 0
0 3 0000000000000401 0

// ==== src.f ====
hw/ompss_pkg.sv
hw/cmd_in_dispatch.sv
hw/cmd_out_collect.sv
hw/lock_manager.sv
hw/ompss_manager.sv
tests/ompss_manager_properties.sv
tests/ompss_manager_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= ompss_manager_tb
RTL_TOP   ?= ompss_manager
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Test failed
PASS_MSG  := Test completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
